//--- common/fetch_cfg.svh
// fetch unit configuration: word width, reset pc, queue sizing and rvc support
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

`define FETCH_XLEN           32       // word width, rv32 only
`define FETCH_PC_INIT        32'h200  // pc after reset

// max accepted requests whose word has not come back yet
`define FETCH_INFLIGHT       3

// parcel queue size, in 16-bit parcels
`define FETCH_QUEUE_DEPTH    18

// stop requesting at this level (parcels)
// depth - (inflight+1) words, so words in flight always fit
`define FETCH_FULL_THRESHOLD 10

// compressed instruction support, 0 gives word aligned fetch only
`define FETCH_HAS_RVC        1

`endif

//--- common/rv_isa_pkg.sv
// rv32 isa types, major opcodes, funct3 codes and fixed instruction encodings
package rv_isa_pkg;

  //////////////////////
  // basic types
  typedef logic [31:0] insn_t;    // full 32-bit instruction
  typedef logic [15:0] parcel_t;  // one compressed parcel
  typedef logic [ 6:0] opcode_t;  // major opcode field
  typedef logic [ 4:0] reg_t;     // register index

  //////////////////////
  // major opcodes used by the rvc expansion
  localparam opcode_t OPC_LOAD   = 7'b000_0011;
  localparam opcode_t OPC_STORE  = 7'b010_0011;
  localparam opcode_t OPC_OP_IMM = 7'b001_0011;
  localparam opcode_t OPC_OP     = 7'b011_0011;
  localparam opcode_t OPC_JAL    = 7'b110_1111;
  localparam opcode_t OPC_JALR   = 7'b110_0111;

  // funct3 values
  localparam logic [2:0] F3_ADD  = 3'b000;  // add, addi, jalr
  localparam logic [2:0] F3_WORD = 3'b010;  // lw, sw

  //////////////////////
  // fixed encodings
  localparam insn_t RV_NOP    = 32'h0000_0013;  // addi x0,x0,0
  localparam insn_t RV_WFI    = 32'h1050_0073;
  localparam insn_t RV_EBREAK = 32'h0010_0073;

endpackage

//--- common/fetch_pkg.sv
// fetch unit types: exception flag struct and parcel read count
package fetch_pkg;

  // exceptions that travel with a fetched instruction
  typedef struct packed {
    logic any;           // or of the three below
    logic illegal;       // reserved or unsupported compressed encoding
    logic access_fault;  // memory returned an error for a used parcel
    logic misaligned;    // redirect target not on a half-word
  } fetch_exc_t;

  // number of parcels removed from the queue head
  typedef logic [1:0] parcel_cnt_t;

  localparam parcel_cnt_t RD_NONE = 2'd0;
  localparam parcel_cnt_t RD_ONE  = 2'd1;  // 16-bit insn
  localparam parcel_cnt_t RD_TWO  = 2'd2;  // 32-bit insn

endpackage

//--- logic/fetch_adr_gen.sv
// instruction memory address register, outstanding request counter and request gating
`include "fetch_cfg.svh"

module fetch_adr_gen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic                   queue_full_i,   // queue almost full
  input  logic                   imem_ack_i,
  input  logic                   imem_valid_i,   // one word returned
  output logic [`FETCH_XLEN-1:0] imem_adr_o,
  output logic                   imem_req_o,
  output logic                   imem_flush_o
);

  // half-word targets allowed with rvc
  localparam logic [`FETCH_XLEN-1:0] ADR_MASK  = (`FETCH_HAS_RVC != 0) ? ~`FETCH_XLEN'(1)
                                                                       : ~`FETCH_XLEN'(3);
  localparam logic [`FETCH_XLEN-1:0] WORD_MASK = ~`FETCH_XLEN'(3);
  localparam int                     INF_W     = $clog2(`FETCH_INFLIGHT + 1);

  logic [INF_W-1:0] inflight_q;  // accepted, not yet returned
  logic             accept;

  assign imem_flush_o = redirect_i;  // memory drops everything in flight
  assign imem_req_o   = ~queue_full_i & ~imem_flush_o &
                        (inflight_q < INF_W'(`FETCH_INFLIGHT));
  assign accept       = imem_req_o & imem_ack_i;

  // address register
  // a redirect may land mid-word, the following fetch is word aligned again
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      imem_adr_o <= `FETCH_PC_INIT & ADR_MASK;
    else if (redirect_i)
      imem_adr_o <= redirect_pc_i & ADR_MASK;
    else if (accept)
      imem_adr_o <= (imem_adr_o + `FETCH_XLEN'(`FETCH_XLEN / 8)) & WORD_MASK;
  end

  // outstanding count, no request during flush so clearing is safe
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      inflight_q <= '0;
    else if (imem_flush_o)
      inflight_q <= '0;
    else if (accept && !imem_valid_i)
      inflight_q <= inflight_q + 1'b1;
    else if (!accept && imem_valid_i)
      inflight_q <= inflight_q - 1'b1;  // same-cycle accept+return keeps count
  end

endmodule

//--- parcel_queue/parcel_queue.sv
// parcel shift queue with per-parcel error bits, drop-first handling and level thresholds
`include "fetch_cfg.svh"

module parcel_queue
  import fetch_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   drop_first_i,   // redirect target is odd half-word
  input  logic                   wr_i,
  input  logic [`FETCH_XLEN-1:0] wr_data_i,
  input  logic                   wr_error_i,
  input  parcel_cnt_t            rd_cnt_i,
  output logic [`FETCH_XLEN-1:0] head_o,         // two parcels, oldest low
  output logic [1:0]             head_error_o,
  output logic                   almost_empty_o,
  output logic                   almost_full_o
);

  localparam int DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int LVL_W = $clog2(DEPTH + 1);

  parcel_t [DEPTH-1:0] q_q, q_d;      // entry 0 is the head
  logic    [DEPTH-1:0] err_q, err_d;  // error per parcel
  logic    [LVL_W-1:0] lvl_q, lvl_d;  // parcels present
  logic    [LVL_W-1:0] lvl_rd;        // level after the read
  logic                drop_q;        // skip low parcel of next word
  parcel_t             wr_lo;         // first parcel to append

  assign wr_lo = drop_q ? wr_data_i[31:16] : wr_data_i[15:0];

  //////////////////////
  // shift out, then append behind what is left
  always_comb
  begin
    q_d    = q_q >> ($bits(parcel_t) * rd_cnt_i);
    err_d  = err_q >> rd_cnt_i;
    lvl_rd = lvl_q - LVL_W'(rd_cnt_i);
    lvl_d  = lvl_rd;

    if (wr_i)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        if (i == int'(lvl_rd))
        begin
          q_d[i]   = wr_lo;
          err_d[i] = wr_error_i;
        end
        else if (i == int'(lvl_rd) + 1 && !drop_q)
        begin
          q_d[i]   = wr_data_i[31:16];  // upper parcel
          err_d[i] = wr_error_i;
        end
      end
      lvl_d = lvl_rd + (drop_q ? LVL_W'(1) : LVL_W'(2));
    end
  end

  //////////////////////
  // control state
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      lvl_q  <= '0;
      drop_q <= 1'b0;
    end
    else if (flush_i)
    begin
      lvl_q  <= '0;  // a write in this cycle is lost on purpose
      drop_q <= drop_first_i & (`FETCH_HAS_RVC != 0);
    end
    else
    begin
      lvl_q <= lvl_d;
      if (wr_i)
        drop_q <= 1'b0;  // only the first word after a flush
    end
  end

  // storage
  always_ff @(posedge clk_i)
  begin
    q_q   <= q_d;
    err_q <= err_d;
  end

  assign head_o       = {q_q[1], q_q[0]};
  assign head_error_o = err_q[1:0];

  // a lone parcel is enough only for a 16-bit insn
  assign almost_empty_o = (lvl_q == '0) ||
                          (lvl_q == LVL_W'(1) && (&q_q[0][1:0] || `FETCH_HAS_RVC == 0));
  assign almost_full_o  = lvl_q >= LVL_W'(`FETCH_FULL_THRESHOLD);

endmodule

//--- rvc/rvc_expander.sv
// compressed rv32 parcel to 32-bit instruction expansion with illegal detection
module rvc_expander
  import rv_isa_pkg::*;
(
  input  parcel_t parcel_i,
  output insn_t   insn_o,
  output logic    illegal_o
);

  //////////////////////
  // encoders
  function automatic insn_t enc_i(logic [11:0] imm, reg_t rs1, logic [2:0] f3, reg_t rd,
                                  opcode_t opc);
    enc_i = {imm, rs1, f3, rd, opc};
  endfunction

  function automatic insn_t enc_add(reg_t rs2, reg_t rs1, reg_t rd);
    enc_add = {7'b000_0000, rs2, rs1, F3_ADD, rd, OPC_OP};
  endfunction

  function automatic insn_t enc_jal(logic [20:0] imm, reg_t rd);
    enc_jal = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  //////////////////////
  // fields
  reg_t        rd;      // ci/cr rd and rs1
  reg_t        rs2;     // cr rs2
  reg_t        rdp;     // rd' or rs2', x8..x15
  reg_t        rs1p;    // rs1'
  logic [11:0] imm_ci;  // signed 6-bit imm
  logic [11:0] imm_lw;  // word offset, zero extended
  logic [20:0] imm_cj;  // jump offset, sign extended

  assign rd     = parcel_i[11:7];
  assign rs2    = parcel_i[6:2];
  assign rdp    = {2'b01, parcel_i[4:2]};
  assign rs1p   = {2'b01, parcel_i[9:7]};
  assign imm_ci = {{7{parcel_i[12]}}, parcel_i[6:2]};
  assign imm_lw = {5'b0, parcel_i[5], parcel_i[12:10], parcel_i[6], 2'b00};
  // offset[11|4|9:8|10|6|7|3:1|5] in parcel bits 12:2
  assign imm_cj = {{10{parcel_i[12]}}, parcel_i[8], parcel_i[10:9], parcel_i[6],
                   parcel_i[7], parcel_i[2], parcel_i[11], parcel_i[5:3], 1'b0};

  //////////////////////
  // decode on funct3 and quadrant
  always_comb
  begin
    insn_o    = {16'h0, parcel_i};  // passed up raw if illegal
    illegal_o = 1'b0;

    case ({parcel_i[15:13], parcel_i[1:0]})
      5'b010_00: insn_o = enc_i(imm_lw, rs1p, F3_WORD, rdp, OPC_LOAD);  // c.lw
      5'b110_00: insn_o = {imm_lw[11:5], rdp, rs1p, F3_WORD, imm_lw[4:0], OPC_STORE};  // c.sw
      5'b000_01: insn_o = enc_i(imm_ci, rd, F3_ADD, rd, OPC_OP_IMM);  // c.addi, c.nop
      5'b001_01: insn_o = enc_jal(imm_cj, 5'd1);                      // c.jal
      5'b010_01: insn_o = enc_i(imm_ci, 5'd0, F3_ADD, rd, OPC_OP_IMM); // c.li
      5'b101_01: insn_o = enc_jal(imm_cj, 5'd0);                      // c.j
      5'b100_10:
      begin
        if (!parcel_i[12])
        begin
          if (rs2 != '0)
            insn_o = enc_add(rs2, 5'd0, rd);  // c.mv
          else if (rd != '0)
            insn_o = enc_i(12'h0, rd, F3_ADD, 5'd0, OPC_JALR);  // c.jr
          else
            illegal_o = 1'b1;  // jr x0 reserved
        end
        else
        begin
          if (rs2 != '0)
            insn_o = enc_add(rs2, rd, rd);  // c.add
          else if (rd != '0)
            insn_o = enc_i(12'h0, rd, F3_ADD, 5'd1, OPC_JALR);  // c.jalr
          else
            insn_o = RV_EBREAK;
        end
      end
      default:   illegal_o = 1'b1;  // incl. all-zero parcel
    endcase
  end

endmodule

//--- logic/insn_stage.sv
// length decode, queue read control, next-pc prediction and the if output registers
`include "fetch_cfg.svh"

module insn_stage
  import fetch_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic                   stall_i,
  input  logic [`FETCH_XLEN-1:0] head_i,
  input  logic [1:0]             head_error_i,
  input  logic                   head_valid_i,
  input  insn_t                  exp_insn_i,
  input  logic                   exp_illegal_i,
  output parcel_cnt_t            rd_cnt_o,
  output parcel_t                rvc_parcel_o,
  output logic [`FETCH_XLEN-1:0] if_predict_pc_o,
  output logic [`FETCH_XLEN-1:0] if_pc_o,
  output insn_t                  if_insn_o,
  output logic                   if_bubble_o,
  output fetch_exc_t             if_exc_o
);

  localparam logic [`FETCH_XLEN-1:0] PC_MASK = (`FETCH_HAS_RVC != 0) ? ~`FETCH_XLEN'(1)
                                                                     : ~`FETCH_XLEN'(3);

  logic [`FETCH_XLEN-1:0] nxt_pc_q;  // pc of the insn at queue head
  logic                   mis_q;     // odd byte redirect pending
  logic                   is_16;
  logic                   take;      // head consumed this cycle
  insn_t                  insn_nxt;
  fetch_exc_t             exc_nxt;

  //////////////////////
  // length decode and read
  assign is_16        = (`FETCH_HAS_RVC != 0) && (head_i[1:0] != 2'b11);
  assign take         = head_valid_i & ~stall_i;
  assign rd_cnt_o     = !take ? RD_NONE : (is_16 ? RD_ONE : RD_TWO);
  assign rvc_parcel_o = head_i[15:0];

  always_comb
  begin
    if (is_16)
      insn_nxt = exp_insn_i;
    else if (head_i == RV_WFI)
      insn_nxt = RV_NOP;  // wfi runs as nop
    else
      insn_nxt = head_i;
  end

  // upper parcel counts only for 32-bit insn
  always_comb
  begin
    exc_nxt.misaligned   = mis_q;
    exc_nxt.access_fault = head_error_i[0] | (~is_16 & head_error_i[1]);
    exc_nxt.illegal      = is_16 & exp_illegal_i;
    exc_nxt.any          = exc_nxt.misaligned | exc_nxt.access_fault | exc_nxt.illegal;
  end

  //////////////////////
  // next pc
  always_comb
  begin
    if (redirect_i)
      if_predict_pc_o = redirect_pc_i & PC_MASK;
    else if (take)
      if_predict_pc_o = nxt_pc_q + (is_16 ? `FETCH_XLEN'(2) : `FETCH_XLEN'(4));
    else
      if_predict_pc_o = nxt_pc_q;
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      nxt_pc_q <= `FETCH_PC_INIT;
      mis_q    <= 1'b0;
    end
    else
    begin
      nxt_pc_q <= if_predict_pc_o;
      if (redirect_i)
        mis_q <= redirect_pc_i[0];
      else if (take)
        mis_q <= 1'b0;  // flagged on first insn only
    end
  end

  //////////////////////
  // if outputs, redirect before stall
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      if_pc_o     <= `FETCH_PC_INIT;
      if_bubble_o <= 1'b1;
      if_exc_o    <= '0;
    end
    else if (redirect_i)
    begin
      if_bubble_o <= 1'b1;
      if_exc_o    <= '0;
    end
    else if (!stall_i)
    begin
      if_pc_o     <= nxt_pc_q;
      if_bubble_o <= ~head_valid_i;
      if (head_valid_i)
        if_exc_o <= exc_nxt;
      else
        if_exc_o <= '0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!redirect_i && !stall_i)
      if_insn_o <= insn_nxt;
  end

endmodule

//--- logic/riscv_fetch.sv
// rv32 fetch unit top: address generator, parcel queue, rvc expander and instruction stage
`include "fetch_cfg.svh"

module riscv_fetch
  import fetch_pkg::*;
  import rv_isa_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // memory request side
  output logic [`FETCH_XLEN-1:0] imem_adr_o,
  output logic                   imem_req_o,
  input  logic                   imem_ack_i,
  output logic                   imem_flush_o,
  // memory return side
  input  logic                   imem_valid_i,
  input  logic [`FETCH_XLEN-1:0] imem_data_i,
  input  logic                   imem_error_i,
  // redirect and back-pressure
  input  logic                   redirect_i,
  input  logic [`FETCH_XLEN-1:0] redirect_pc_i,
  input  logic                   stall_i,
  // towards decode
  output logic [`FETCH_XLEN-1:0] if_pc_o,
  output insn_t                  if_insn_o,
  output logic                   if_bubble_o,
  output fetch_exc_t             if_exc_o,
  output logic [`FETCH_XLEN-1:0] if_predict_pc_o
);

  logic                   queue_full;   // stop requests
  logic                   queue_empty;  // no complete insn at head
  logic [`FETCH_XLEN-1:0] head;
  logic [1:0]             head_error;
  parcel_cnt_t            rd_cnt;
  parcel_t                rvc_parcel;
  insn_t                  exp_insn;
  logic                   exp_illegal;

  fetch_adr_gen u_adr_gen (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .redirect_i    ( redirect_i    ),
    .redirect_pc_i ( redirect_pc_i ),
    .queue_full_i  ( queue_full    ),
    .imem_ack_i    ( imem_ack_i    ),
    .imem_valid_i  ( imem_valid_i  ),
    .imem_adr_o    ( imem_adr_o    ),
    .imem_req_o    ( imem_req_o    ),
    .imem_flush_o  ( imem_flush_o  )
  );

  parcel_queue u_queue (
    .clk_i          ( clk_i             ),
    .rst_ni         ( rst_ni            ),
    .flush_i        ( imem_flush_o      ),
    .drop_first_i   ( redirect_pc_i[1]  ),  // odd half-word target
    .wr_i           ( imem_valid_i      ),
    .wr_data_i      ( imem_data_i       ),
    .wr_error_i     ( imem_error_i      ),
    .rd_cnt_i       ( rd_cnt            ),
    .head_o         ( head              ),
    .head_error_o   ( head_error        ),
    .almost_empty_o ( queue_empty       ),
    .almost_full_o  ( queue_full        )
  );

  rvc_expander u_rvc (
    .parcel_i  ( rvc_parcel  ),
    .insn_o    ( exp_insn    ),
    .illegal_o ( exp_illegal )
  );

  insn_stage u_insn (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .redirect_i      ( redirect_i      ),
    .redirect_pc_i   ( redirect_pc_i   ),
    .stall_i         ( stall_i         ),
    .head_i          ( head            ),
    .head_error_i    ( head_error      ),
    .head_valid_i    ( ~queue_empty    ),
    .exp_insn_i      ( exp_insn        ),
    .exp_illegal_i   ( exp_illegal     ),
    .rd_cnt_o        ( rd_cnt          ),
    .rvc_parcel_o    ( rvc_parcel      ),
    .if_predict_pc_o ( if_predict_pc_o ),
    .if_pc_o         ( if_pc_o         ),
    .if_insn_o       ( if_insn_o       ),
    .if_bubble_o     ( if_bubble_o     ),
    .if_exc_o        ( if_exc_o        )
  );

endmodule

//--- dv/imem_model.sv
// instruction memory model: fixed program image, random ack and return delay, error word
module imem_model #(
  parameter logic [31:0] ERR_ADR = 32'h300  // word that returns with error
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] adr_i,
  input  logic        req_i,
  output logic        ack_o,
  input  logic        flush_i,
  output logic        valid_o,
  output logic [31:0] data_o,
  output logic        error_o
);

  logic [31:0] mem [256];     // 1 KiB image, address wraps
  logic [31:0] pend_adr [$];  // accepted, in order
  int unsigned pend_due [$];  // cycle when the word may return
  int unsigned cyc;
  int unsigned due;
  logic [31:0] adr_s;
  logic [31:0] ret_adr;
  logic        accepted;
  logic        flushed;

  //////////////////////
  // program image
  initial
  begin
    cyc     = 0;
    ack_o   = 1'b0;
    valid_o = 1'b0;
    data_o  = '0;
    error_o = 1'b0;
    // fill: addi x(i), x0, i, low bits 11 so always word aligned 32-bit
    for (int i = 0; i < 256; i++)
      mem[i] = {4'h0, i[7:0], 5'd0, 3'b000, i[4:0], 7'h13};
    mem[128] = 32'h0010_0093;  // 0x200 addi x1,x0,1
    mem[129] = 32'h1050_0073;  // wfi
    mem[130] = 32'h0020_8113;  // addi x2,x1,2
    mem[160] = 32'h0193_4515;  // 0x280 c.li, then straddling addi
    mem[161] = 32'h85aa_0070;  // c.mv
    mem[162] = 32'h4044_95aa;  // c.add, c.lw
    mem[163] = 32'ha011_c404;  // c.sw, c.j
    mem[164] = 32'h10fd_3ffd;  // c.jal, c.addi
    mem[165] = 32'h9282_8082;  // c.jr, c.jalr
    mem[166] = 32'h0001_9002;  // c.ebreak, c.nop
    mem[176] = 32'h4012_0000;  // 0x2c0 zero parcel, c.lwsp rd0
    mem[177] = 32'h0001_6101;  // c.addi16sp imm 0, c.nop
    mem[191] = 32'h0213_0001;  // 0x2fc c.nop, addi straddles into error word
    mem[192] = 32'h0001_0090;
    mem[208] = 32'h4515_0001;  // 0x342 target in upper half
  end

  //////////////////////
  // handshake and in-order return
  always @(posedge clk_i)
  begin
    accepted = req_i & ack_o & rst_ni;  // values from before the edge
    flushed  = flush_i;
    adr_s    = adr_i;
    cyc      = cyc + 1;
    #1;
    valid_o = 1'b0;
    error_o = 1'b0;
    if (flushed)
    begin
      pend_adr.delete();  // drop everything in flight
      pend_due.delete();
    end
    else
    begin
      if (accepted)
      begin
        due = cyc + 1 + $urandom_range(0, 3);
        if (pend_due.size() > 0 && due <= pend_due[$])
          due = pend_due[$] + 1;  // keep order
        pend_adr.push_back(adr_s);
        pend_due.push_back(due);
      end
      if (pend_adr.size() > 0 && pend_due[0] <= cyc)
      begin
        ret_adr = pend_adr.pop_front();
        void'(pend_due.pop_front());
        valid_o = 1'b1;
        data_o  = mem[ret_adr[9:2]];
        error_o = (ret_adr[9:2] == ERR_ADR[9:2]);
      end
    end
    ack_o = rst_ni && ($urandom_range(0, 3) != 0);  // ack about 3 of 4 cycles
  end

endmodule

//--- dv/tb_riscv_fetch.sv
// testbench for the fetch unit: clock, reset, tests, reference walk, assertions, timeout
module tb_riscv_fetch
  import fetch_pkg::*;
();

  localparam logic [31:0] ERR_ADR   = 32'h300;
  localparam int          NUM_TESTS = 6;
  localparam int          TIMEOUT   = 200 * NUM_TESTS;  // cycles

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] imem_adr, imem_data, redirect_pc_i, if_pc, if_insn, if_predict_pc;
  logic        imem_req, imem_ack, imem_flush, imem_valid, imem_error;
  logic        redirect_i, stall_i, if_bubble;
  fetch_exc_t  if_exc;

  logic [31:0] image [256];  // copy of the memory image
  logic [31:0] ref_pc, exp_insn;
  logic [31:0] last_predict;  // predicted pc seen before the last edge
  logic        ref_mis;
  fetch_exc_t  exp_exc;
  int          exp_len, consumed, outstanding, cycles, errors, tests, failed;

  riscv_fetch UUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .imem_adr_o (imem_adr), .imem_req_o (imem_req), .imem_ack_i (imem_ack),
    .imem_flush_o (imem_flush), .imem_valid_i (imem_valid), .imem_data_i (imem_data),
    .imem_error_i (imem_error), .redirect_i (redirect_i), .redirect_pc_i (redirect_pc_i),
    .stall_i (stall_i), .if_pc_o (if_pc), .if_insn_o (if_insn), .if_bubble_o (if_bubble),
    .if_exc_o (if_exc), .if_predict_pc_o (if_predict_pc)
  );

  imem_model #(.ERR_ADR(ERR_ADR)) u_imem (
    .clk_i (clk_i), .rst_ni (rst_ni), .adr_i (imem_adr), .req_i (imem_req),
    .ack_o (imem_ack), .flush_i (imem_flush), .valid_o (imem_valid),
    .data_o (imem_data), .error_o (imem_error)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////
  // reference model
  function automatic logic [15:0] parcel_at(input logic [31:0] a);
    logic [31:0] w;
    w = image[a[9:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // rvc subset per isa manual, returns {illegal, rv32 word}
  function automatic logic [32:0] expand_c(input logic [15:0] c);
    logic [4:0]  r, s;
    logic [11:0] i6, lw;
    logic [20:0] j;
    logic [31:0] w;
    logic        bad;
    r   = c[11:7];
    s   = c[6:2];
    i6  = {{6{c[12]}}, c[12], c[6:2]};
    lw  = {5'd0, c[5], c[12:10], c[6], 2'b00};
    j   = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
    w   = {16'd0, c};  // raw parcel when illegal
    bad = 1'b0;
    case ({c[15:13], c[1:0]})
      5'b010_00: w = {lw, 2'b01, c[9:7], 3'b010, 2'b01, c[4:2], 7'h03};
      5'b110_00: w = {lw[11:5], 2'b01, c[4:2], 2'b01, c[9:7], 3'b010, lw[4:0], 7'h23};
      5'b000_01: w = {i6, r, 3'b000, r, 7'h13};
      5'b010_01: w = {i6, 5'd0, 3'b000, r, 7'h13};
      5'b001_01: w = {j[20], j[10:1], j[11], j[19:12], 5'd1, 7'h6f};
      5'b101_01: w = {j[20], j[10:1], j[11], j[19:12], 5'd0, 7'h6f};
      5'b100_10:
      begin
        if (s != 5'd0)
          w = {7'd0, s, (c[12] ? r : 5'd0), 3'b000, r, 7'h33};  // add or mv
        else if (r != 5'd0)
          w = {12'd0, r, 3'b000, {4'd0, c[12]}, 7'h67};         // jalr or jr
        else if (c[12])
          w = 32'h0010_0073;
        else
          bad = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    return {bad, w};
  endfunction

  always_comb
  begin
    logic [15:0] p0;
    logic [32:0] ex;
    p0 = parcel_at(ref_pc);
    ex = expand_c(p0);
    exp_exc.misaligned = ref_mis;
    if (p0[1:0] == 2'b11)
    begin
      exp_insn = {parcel_at(ref_pc + 32'd2), p0};
      if (exp_insn == 32'h1050_0073)
        exp_insn = 32'h0000_0013;  // wfi as nop
      exp_len              = 4;
      exp_exc.illegal      = 1'b0;
      exp_exc.access_fault = (ref_pc[9:2] == ERR_ADR[9:2]) ||
                             (((ref_pc + 32'd2) >> 2) & 32'hff) == {24'd0, ERR_ADR[9:2]};
    end
    else
    begin
      exp_insn             = ex[31:0];
      exp_len              = 2;
      exp_exc.illegal      = ex[32];
      exp_exc.access_fault = (ref_pc[9:2] == ERR_ADR[9:2]);
    end
    exp_exc.any = exp_exc.misaligned | exp_exc.illegal | exp_exc.access_fault;
  end

  // walk the image as decode consumes instructions
  always @(posedge clk_i or negedge rst_ni)
  begin
    last_predict = if_predict_pc;  // pc of the insn that comes next
    if (!rst_ni)
    begin
      ref_pc      = 32'h200;
      ref_mis     = 1'b0;
      consumed    = 0;
      outstanding = 0;
    end
    else
    begin
      if (redirect_i)
      begin
        ref_pc  = redirect_pc_i & ~32'd1;
        ref_mis = redirect_pc_i[0];
      end
      else if (!stall_i && !if_bubble)
      begin
        ref_pc   = ref_pc + exp_len;
        ref_mis  = 1'b0;
        consumed = consumed + 1;
      end
      if (imem_flush)
        outstanding = 0;
      else
        outstanding = outstanding + int'(imem_req & imem_ack) - int'(imem_valid);
    end
  end

  ////////////////////
  // checks
  a_output: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !if_bubble |-> (if_pc == ref_pc && if_insn == exp_insn && if_exc == exp_exc))
    else
    begin
      errors++;
      $display("Mismatch at %0t: pc %h insn %h exc %b, expected pc %h insn %h exc %b",
               $time, $sampled(if_pc), $sampled(if_insn), $sampled(if_exc),
               $sampled(ref_pc), $sampled(exp_insn), $sampled(exp_exc));
    end

  // next pc is the head insn when bubbled, else the one after the output insn
  a_predict: assert property (@(posedge clk_i) disable iff (!rst_ni)
    last_predict == (if_bubble ? ref_pc : ref_pc + 32'(exp_len)))
    else
    begin
      errors++;
      $display("Mismatch at %0t: predicted pc %h, expected %h", $time,
               $sampled(last_predict),
               $sampled(if_bubble) ? $sampled(ref_pc)
                                   : $sampled(ref_pc) + 32'($sampled(exp_len)));
    end

  a_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stall_i && !redirect_i) |=> ($stable(if_pc) && $stable(if_insn) &&
                                  $stable(if_bubble) && $stable(if_exc)))
    else
    begin
      errors++;
      $display("Mismatch at %0t: outputs changed while stalled", $time);
    end

  a_inflight: assert property (@(posedge clk_i) disable iff (!rst_ni) outstanding <= 3)
    else
    begin
      errors++;
      $display("more than 3 memory requests outstanding at time %0t", $time);
    end

  // watchdog
  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles >= TIMEOUT)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////
  // tests
  task automatic run_test(input string name, input logic jump, input logic [31:0] target,
                          input int n, input logic stalls);
    int err0;
    int base;
    err0 = errors;
    if (jump)
    begin
      @(posedge clk_i);
      #1 redirect_i = 1'b1;
      redirect_pc_i = target;
      @(posedge clk_i);
      #1 redirect_i = 1'b0;
    end
    base = consumed;
    while (consumed < base + n)
    begin
      @(posedge clk_i);
      #1;
      if (stalls && !if_bubble && $urandom_range(0, 3) == 0)
      begin
        stall_i = 1'b1;  // hold a random stretch
        repeat ($urandom_range(3, 12)) @(posedge clk_i);
        #1 stall_i = 1'b0;
      end
    end
    tests++;
    if (errors == err0)
      $display("test %s: ok", name);
    else
    begin
      failed++;
      $display("test %s: failed, %0d errors", name, errors - err0);
    end
  endtask

  initial
  begin
    void'($urandom(32'h17bc34b9));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    stall_i       = 1'b0;
    errors        = 0;
    tests         = 0;
    failed        = 0;
    cycles        = 0;
    repeat (3) @(posedge clk_i);
    for (int i = 0; i < 256; i++)
      image[i] = u_imem.mem[i];
    #1 rst_ni = 1'b1;
    run_test("sequential 32-bit", 1'b0, 32'h200, 6, 1'b0);
    run_test("mixed 16/32-bit", 1'b1, 32'h280, 14, 1'b0);
    run_test("reserved compressed", 1'b1, 32'h2c0, 4, 1'b0);
    run_test("access fault", 1'b1, 32'h2fc, 4, 1'b0);
    run_test("odd half-word redirect", 1'b1, 32'h342, 4, 1'b0);
    run_test("stall", 1'b1, 32'h280, 20, 1'b1);
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- riscv_fetch.f
+incdir+common
common/rv_isa_pkg.sv
common/fetch_pkg.sv
logic/fetch_adr_gen.sv
parcel_queue/parcel_queue.sv
rvc/rvc_expander.sv
logic/insn_stage.sv
logic/riscv_fetch.sv
dv/imem_model.sv
dv/tb_riscv_fetch.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -Wno-fatal --top-module tb_riscv_fetch \
		-f riscv_fetch.f -o sim_tb

run: build
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; \
		echo "$$out" | grep -qx "Done: no errors"

lint:
	verilator --lint-only +incdir+common --top-module riscv_fetch \
		common/rv_isa_pkg.sv common/fetch_pkg.sv logic/fetch_adr_gen.sv \
		parcel_queue/parcel_queue.sv rvc/rvc_expander.sv logic/insn_stage.sv \
		logic/riscv_fetch.sv

clean:
	rm -rf obj_dir
